//--- project.f
+incdir+sim
design/riscv_isa_pkg.sv
design/core_pkg.sv
design/insn_decoder.sv
design/reg_file.sv
design/alu.sv
design/pc_control.sv
design/rv_core.sv
sim/tb_rv_core.sv

//--- sim/tb_ref_model.svh
// architectural state of the reference model
word_t    model_regs [32];
word_t    model_pc;

// predicted outputs for the instruction at model_pc
logic     exp_we;
reg_idx_t exp_rd;
word_t    exp_data;
logic     exp_halt;
logic     exp_illegal;
word_t    exp_next_pc;

task automatic clear_arch_state();
  for (int i = 0; i < 32; i++) begin
    model_regs[i] = '0;
  end
  model_pc = '0;
endtask

// integer op selected by funct3, alt picks sub or the arithmetic shift
function automatic word_t alu_result(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
  word_t r;
  case (f3)
    f3_add_sub: r = alt ? a - b : a + b;
    f3_sll:     r = a << b[4:0];
    f3_slt:     r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    f3_sltu:    r = (a < b) ? 32'd1 : 32'd0;
    f3_xor:     r = a ^ b;
    f3_srl_sra: begin
      if (alt) begin
        r = $signed(a) >>> b[4:0];
      end else begin
        r = a >> b[4:0];
      end
    end
    f3_or:      r = a | b;
    default:    r = a & b;
  endcase
  return r;
endfunction

task automatic predict_outputs();
  word_t      w;
  logic [2:0] f3;
  logic [6:0] f7;
  word_t      a;
  word_t      b;
  logic       taken;
  w  = prog[model_pc[addr_w+1:2]];
  f3 = w[14:12];
  f7 = w[31:25];
  a  = model_regs[w[19:15]];
  b  = model_regs[w[24:20]];
  exp_we      = 1'b0;
  exp_rd      = w[11:7];
  exp_data    = '0;
  exp_halt    = 1'b0;
  exp_illegal = 1'b0;
  exp_next_pc = model_pc + word_t'(insn_bytes);
  case (w[6:0])
    op_lui: begin
      exp_we   = 1'b1;
      exp_data = {w[31:12], 12'h000};
    end
    op_reg_imm: begin
      if ((f3 == f3_sll && f7 != f7_base) ||
          (f3 == f3_srl_sra && f7 != f7_base && f7 != f7_alt)) begin
        exp_illegal = 1'b1;
      end else begin
        exp_we   = 1'b1;
        exp_data = alu_result(f3, f3 == f3_srl_sra && f7 == f7_alt, a,
                              {{20{w[31]}}, w[31:20]});
      end
    end
    op_reg_reg: begin
      if (f7 == f7_base || (f7 == f7_alt && (f3 == f3_add_sub || f3 == f3_srl_sra))) begin
        exp_we   = 1'b1;
        exp_data = alu_result(f3, f7 == f7_alt, a, b);
      end else begin
        exp_illegal = 1'b1;
      end
    end
    op_branch: begin
      case (f3)
        f3_beq:  taken = (a == b);
        f3_bne:  taken = (a != b);
        f3_blt:  taken = ($signed(a) < $signed(b));
        f3_bge:  taken = ($signed(a) >= $signed(b));
        f3_bltu: taken = (a < b);
        default: taken = (a >= b);
      endcase
      if (f3 == 3'd2 || f3 == 3'd3) begin
        exp_illegal = 1'b1;  // no such branch
      end else if (taken) begin
        exp_next_pc = model_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
    end
    op_environ: begin
      if (w[31:7] == '0) begin
        exp_halt    = 1'b1;
        exp_next_pc = model_pc;  // ecall parks the core
      end else begin
        exp_illegal = 1'b1;
      end
    end
    default: exp_illegal = 1'b1;
  endcase
  if (exp_rd == '0) begin
    exp_we = 1'b0;
  end
endtask

task automatic apply_retire();
  if (exp_we) begin
    model_regs[exp_rd] = exp_data;
  end
  model_pc = exp_next_pc;
endtask

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core
  import riscv_isa_pkg::*;
  import core_pkg::*;
();

  localparam int prog_len     = 64;
  localparam int addr_w       = $clog2(prog_len);
  localparam int clk_period   = 40;
  localparam int reset_cycles = 10;
  localparam int halt_timeout = 200;
  localparam int hold_cycles  = 5;

  logic  clk;
  logic  rst;
  word_t insn;
  word_t pc;
  wb_t   wb;
  logic  halt;
  logic  illegal;

  word_t       prog [prog_len];
  logic [31:0] lfsr_state;

  `include "tb_ref_model.svh"

  rv_core rv_core_inst (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .pc      (pc),
    .wb      (wb),
    .halt    (halt),
    .illegal (illegal)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  // instruction memory, word addressed by pc
  assign insn = $isunknown(pc) ? '0 : prog[pc[addr_w+1:2]];

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    end else begin
      return s >> 1;
    end
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  task automatic build_program();
    int          kind;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    word_t       off;
    // addi x1, x5, 0 reads a register that only reset has cleared
    prog[0] = {12'h000, 5'd5, f3_add_sub, 5'd1, op_reg_imm};
    for (int i = 1; i < prog_len - 1; i++) begin
      kind = int'(rand_bits(3));
      rd   = reg_idx_t'(rand_bits(3));  // x0 to x7 so operands collide often
      rs1  = reg_idx_t'(rand_bits(3));
      rs2  = reg_idx_t'(rand_bits(3));
      f3   = 3'(rand_bits(3));
      if ((kind == 5 || kind == 6) && i > prog_len - 5) begin
        kind = 3;  // no room left for a forward branch
      end
      case (kind)
        0: prog[i] = {20'(rand_bits(20)), rd, op_lui};
        1, 2: begin
          if (f3 == f3_sll) begin
            imm = {f7_base, 5'(rand_bits(5))};
          end else if (f3 == f3_srl_sra) begin
            imm = {((rand_bits(1) != 0) ? f7_alt : f7_base), 5'(rand_bits(5))};
          end else begin
            imm = 12'(rand_bits(12));
          end
          prog[i] = {imm, rs1, f3, rd, op_reg_imm};
        end
        3, 4: begin
          f7 = f7_base;
          if ((f3 == f3_add_sub || f3 == f3_srl_sra) && rand_bits(1) != 0) begin
            f7 = f7_alt;
          end
          prog[i] = {f7, rs2, rs1, f3, rd, op_reg_reg};
        end
        5, 6: begin
          if (f3 == 3'd2 || f3 == 3'd3) begin
            f3[2] = 1'b1;  // becomes bltu or bgeu
          end
          off     = word_t'((rand_bits(2) + 1) * insn_bytes);  // 4 to 16 bytes ahead
          prog[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
        end
        default: begin
          case (rand_bits(2))
            0:       prog[i] = {7'b000_0000, rs2, rs1, 2'b01, f3[0], 5'b0100_0, op_branch};
            1:       prog[i] = {7'b000_0001, rs2, rs1, f3, rd, op_reg_reg};  // mul group
            2:       prog[i] = {12'(rand_bits(12)), rs1, f3, rd, 7'b000_0011};  // load
            default: prog[i] = {12'h001, 13'h0000, op_environ};  // ebreak
          endcase
        end
      endcase
    end
    prog[prog_len-1] = {25'h0, op_environ};  // ecall
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic compare_retire();
    predict_outputs();
    expect_equal("pc", pc, model_pc);
    expect_equal("halt", 32'(halt), 32'(exp_halt));
    expect_equal("illegal", 32'(illegal), 32'(exp_illegal));
    expect_equal("wb.we", 32'(wb.we), 32'(exp_we));
    if (exp_we) begin
      expect_equal("wb.rd", 32'(wb.rd), 32'(exp_rd));
      expect_equal("wb.data", wb.data, exp_data);
    end
  endtask

  task automatic run_until_halt();
    int cycles;
    cycles = 0;
    while (halt !== 1'b1) begin
      if (cycles >= halt_timeout) begin
        abort_run("timeout: halt never came within 200 cycles");
      end
      compare_retire();
      apply_retire();
      @(negedge clk);
      cycles++;
    end
    compare_retire();
    repeat (hold_cycles) begin  // parked core keeps pc and writes nothing
      apply_retire();
      @(negedge clk);
      compare_retire();
    end
  endtask

  initial begin
    rst        = 1'b1;
    lfsr_state = 32'h4619;
    for (int run = 0; run < 2; run++) begin
      if (run > 0) begin
        @(negedge clk);
        rst = 1'b1;
      end
      build_program();  // lfsr carries on, second run gets a new program
      clear_arch_state();
      repeat (reset_cycles) @(negedge clk);
      rst = 1'b0;
      run_until_halt();
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps

module rv_core
  import riscv_isa_pkg::*;
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  word_t insn,
  output word_t pc,
  output wb_t   wb,
  output logic  halt,
  output logic  illegal
);

  ctrl_t    ctrl;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    result;

  insn_decoder insn_decoder_inst (
    .insn (insn),
    .ctrl (ctrl),
    .rs1  (rs1),
    .rs2  (rs2),
    .rd   (rd)
  );

  reg_file reg_file_inst (
    .clk      (clk),
    .rst      (rst),
    .wb       (wb),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu alu_inst (
    .ctrl     (ctrl),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (result)
  );

  pc_control pc_control_inst (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc)
  );

  // retire port doubles as the register write
  assign wb = '{we: ctrl.reg_we, rd: rd, data: result};

  assign halt    = ctrl.is_halt;
  assign illegal = ctrl.illegal;

endmodule

//--- design/pc_control.sv
`timescale 1ns/1ps

module pc_control
  import riscv_isa_pkg::*;
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  ctrl_t ctrl,
  input  word_t rs1_data,
  input  word_t rs2_data,
  output word_t pc
);

  logic  taken;
  word_t next_pc;

  // branch condition per funct3
  always_comb begin
    case (ctrl.funct3)
      f3_beq:  taken = (rs1_data == rs2_data);
      f3_bne:  taken = (rs1_data != rs2_data);
      f3_blt:  taken = $signed(rs1_data) < $signed(rs2_data);
      f3_bge:  taken = $signed(rs1_data) >= $signed(rs2_data);
      f3_bltu: taken = rs1_data < rs2_data;
      f3_bgeu: taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (ctrl.is_halt) begin
      next_pc = pc;  // hold until reset
    end else if (ctrl.is_branch && taken) begin
      next_pc = pc + ctrl.imm;
    end else begin
      next_pc = pc + word_t'(insn_bytes);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

  // fetch stays word aligned over branches too
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00
  ) else $error("pc not word aligned");

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu
  import riscv_isa_pkg::*;
  import core_pkg::*;
(
  input  ctrl_t ctrl,
  input  word_t rs1_data,
  input  word_t rs2_data,
  output word_t result
);

  word_t              op_b;
  logic [shamt_w-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  assign op_b  = ctrl.use_imm ? ctrl.imm : rs2_data;
  assign shamt = op_b[shamt_w-1:0];  // upper bits ignored

  assign lt_signed   = $signed(rs1_data) < $signed(op_b);
  assign lt_unsigned = rs1_data < op_b;

  always_comb begin
    case (ctrl.alu_op)
      alu_add:    result = rs1_data + op_b;
      alu_sub:    result = rs1_data - op_b;
      alu_sll:    result = rs1_data << shamt;
      alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:    result = rs1_data ^ op_b;
      alu_srl:    result = rs1_data >> shamt;
      alu_sra:    result = $signed(rs1_data) >>> shamt;  // sign fill
      alu_or:     result = rs1_data | op_b;
      alu_and:    result = rs1_data & op_b;
      alu_pass_b: result = op_b;
      default:    result = '0;
    endcase
  end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file
  import riscv_isa_pkg::*;
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  wb_t      wb,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  localparam int num_regs = 2 ** reg_w;

  word_t regs [num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we) begin
      regs[wb.rd] <= wb.data;  // decoder already filters rd zero
    end
  end

  // x0 reads as zero regardless of array contents
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // the decoder owns the x0 write rule
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (rst)
    wb.we |-> (wb.rd != '0)
  ) else $error("register write to x0 with we high");

endmodule

//--- design/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder
  import riscv_isa_pkg::*;
  import core_pkg::*;
(
  input  insn_t    insn,
  output ctrl_t    ctrl,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd
);

  word_t      raw;
  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_u;

  // op for funct3 with funct7 at its base value
  function automatic alu_op_t base_op(input logic [2:0] f3);
    case (f3)
      f3_add_sub: return alu_add;
      f3_sll:     return alu_sll;
      f3_slt:     return alu_slt;
      f3_sltu:    return alu_sltu;
      f3_xor:     return alu_xor;
      f3_srl_sra: return alu_srl;
      f3_or:      return alu_or;
      default:    return alu_and;
    endcase
  endfunction

  assign raw    = insn;
  assign opcode = insn.r_fmt.opcode;
  assign funct3 = insn.r_fmt.funct3;
  assign funct7 = insn.r_fmt.funct7;

  assign rs1 = insn.r_fmt.rs1;
  assign rs2 = insn.r_fmt.rs2;
  assign rd  = insn.r_fmt.rd;

  assign imm_i = {{20{insn.i_fmt.imm[11]}}, insn.i_fmt.imm};  // low 5 bits double as shamt
  assign imm_b = {{19{insn.b_fmt.imm_12}}, insn.b_fmt.imm_12, insn.b_fmt.imm_11,
                  insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {raw[31:12], 12'b0};

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = alu_add;
    ctrl.funct3 = funct3;

    case (opcode)
      op_lui: begin
        ctrl.alu_op  = alu_pass_b;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_u;
        ctrl.reg_we  = 1'b1;
      end
      op_reg_imm: begin
        ctrl.alu_op  = base_op(funct3);
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_i;
        ctrl.reg_we  = 1'b1;
        // shifts carry funct7 in the upper immediate bits
        if (funct3 == f3_sll) begin
          ctrl.illegal = (funct7 != f7_base);
        end else if (funct3 == f3_srl_sra) begin
          if (funct7 == f7_alt) begin
            ctrl.alu_op = alu_sra;
          end else if (funct7 != f7_base) begin
            ctrl.illegal = 1'b1;
          end
        end
      end
      op_reg_reg: begin
        ctrl.alu_op = base_op(funct3);
        ctrl.reg_we = 1'b1;
        if (funct7 == f7_alt) begin
          if (funct3 == f3_add_sub) begin
            ctrl.alu_op = alu_sub;
          end else if (funct3 == f3_srl_sra) begin
            ctrl.alu_op = alu_sra;
          end else begin
            ctrl.illegal = 1'b1;
          end
        end else if (funct7 != f7_base) begin
          ctrl.illegal = 1'b1;  // M extension and others not supported
        end
      end
      op_branch: begin
        ctrl.imm = imm_b;
        case (funct3)
          f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu: ctrl.is_branch = 1'b1;
          default: ctrl.illegal = 1'b1;  // funct3 2 and 3 unused
        endcase
      end
      op_environ: begin
        // only ecall, everything above the opcode must be zero
        if (raw[31:7] == '0) begin
          ctrl.is_halt = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase

    if (ctrl.illegal) begin  // no-op, pc still steps by 4
      ctrl.reg_we    = 1'b0;
      ctrl.is_branch = 1'b0;
    end
    if (rd == '0) begin
      ctrl.reg_we = 1'b0;  // x0 writes dropped here
    end
  end

endmodule

//--- design/core_pkg.sv
package core_pkg;

  import riscv_isa_pkg::*;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b  // lui: immediate straight through
  } alu_op_t;

  // decoded control for the instruction at the current pc
  typedef struct packed {
    alu_op_t    alu_op;
    logic       use_imm;    // operand b is imm, not rs2
    word_t      imm;        // sign extended, or upper imm for lui
    logic       reg_we;
    logic       is_branch;
    logic [2:0] funct3;     // branch condition select
    logic       is_halt;    // ecall
    logic       illegal;
  } ctrl_t;

  // register write, also the retire port of the core
  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    data;
  } wb_t;

endpackage

//--- design/riscv_isa_pkg.sv
package riscv_isa_pkg;

  localparam int xlen    = 32;
  localparam int reg_w   = 5;
  localparam int shamt_w = $clog2(xlen);  // shift amount width

  typedef logic [reg_w-1:0] reg_idx_t;
  typedef logic [xlen-1:0]  word_t;
  typedef logic [6:0]       opcode_t;

  // major opcodes of the kept subset
  localparam opcode_t op_lui     = 7'b01_101_11;
  localparam opcode_t op_reg_imm = 7'b00_100_11;
  localparam opcode_t op_reg_reg = 7'b01_100_11;
  localparam opcode_t op_branch  = 7'b11_000_11;
  localparam opcode_t op_environ = 7'b11_100_11;

  // funct3 for the integer operations
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3 for the conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [6:0] f7_base = 7'b000_0000;
  localparam logic [6:0] f7_alt  = 7'b010_0000;  // sub, sra, srai

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;      // also funct7 + shamt for shifts
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_t     opcode;
  } i_fmt_t;

  // branch offset is scattered over the word, bit 0 is implied zero
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
  } insn_t;

  localparam int insn_bytes = 4;  // pc step

endpackage
